// File: Makefile
SIM      = verilator
TOP      = tb_lsu_top
FILELIST = list.f
OBJ_DIR  = obj_dir
FLAGS    = --timing --assert --top-module $(TOP)

.PHONY: all lint sim clean

all: sim

# Static checks on the whole file list
lint:
	$(SIM) --lint-only $(FLAGS) -f $(FILELIST)

# Build and run, the exit status carries pass or fail
sim:
	$(SIM) --binary $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: dc_data_ram.sv
/* Data-cache word array with combinational read and byte-enabled
   synchronous write, no tags so every access hits */

`timescale 1ns/1ns

module dc_data_ram (
    input  logic                             i_clk,

    // Shared byte address, word index taken from bits above the lane bits
    input  procyon_types::procyon_addr_t     i_addr,

    // Read port, returns zero while not enabled
    input  logic                             i_re,
    output procyon_types::procyon_data_t     o_rd_data,

    // Write port, only the enabled byte lanes are updated
    input  logic                             i_we,
    input  procyon_types::procyon_byte_en_t  i_byte_en,
    input  procyon_types::procyon_data_t     i_wr_data
);

    procyon_types::procyon_data_u               mem [procyon_types::DC_DEPTH];
    logic [procyon_types::DC_INDEX_WIDTH-1:0]   index;
    procyon_types::procyon_data_u               wr_word;

    // Aligned word index, the two lane bits select bytes inside the word
    assign index = i_addr[procyon_types::DC_INDEX_WIDTH+1:2];

    // Store data viewed as lanes so each can be merged on its own
    assign wr_word.word = i_wr_data;

    // Combinational read, a store in the same cycle is seen after the edge
    always_comb begin
        if (i_re) begin
            o_rd_data = mem[index].word;
        end else begin
            o_rd_data = '0;
        end
    end

    // Merge enabled lanes into the addressed word at the clock edge
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            for (int lane = 0; lane < procyon_types::DATA_BYTES; lane++) begin
                if (i_byte_en[lane]) begin
                    mem[index].bytes[lane] <= wr_word.bytes[lane];
                end
            end
        end
    end

endmodule

// File: list.f
procyon_types.sv
procyon_lsu_pkg.sv
lsu_ag.sv
dc_data_ram.sv
lsu_ex.sv
lsu_top.sv
lsu_top_asserts.sv
tb_lsu_top.sv

// File: lsu_ag.sv
/* LSU address-generation stage: registers the op, its effective address,
   store byte enables and lane-shifted store data */

`timescale 1ns/1ns

module lsu_ag (
    input  logic                              i_clk,
    input  logic                              i_arst_n,

    // Op presented by the issue side, sampled when i_valid is high
    input  logic                              i_valid,
    input  procyon_lsu_pkg::procyon_lsu_func_t i_lsu_func,
    input  procyon_types::procyon_addr_t      i_base,
    input  procyon_types::procyon_addr_t      i_offset,
    input  procyon_types::procyon_tag_t       i_tag,
    input  procyon_types::procyon_data_t      i_store_data,

    // Registered op for the execute stage
    output logic                              o_valid,
    output procyon_lsu_pkg::procyon_lsu_func_t o_lsu_func,
    output procyon_types::procyon_addr_t      o_addr,
    output procyon_types::procyon_tag_t       o_tag,

    // Registered store payload for the data array
    output procyon_types::procyon_data_t      o_store_data,
    output procyon_types::procyon_byte_en_t   o_byte_en
);

    procyon_types::procyon_addr_t     addr;
    logic [1:0]                       size;
    logic                             is_store;
    procyon_types::procyon_byte_en_t  byte_en;
    procyon_types::procyon_data_t     store_data;

    // Effective address is simply base plus offset
    assign addr     = i_base + i_offset;
    assign size     = procyon_lsu_pkg::lsu_func_size(i_lsu_func);
    assign is_store = procyon_lsu_pkg::lsu_func_is_store(i_lsu_func);

    // Byte enables come from the access size and the low address bits
    // Loads and idle cycles leave every lane disabled
    always_comb begin
        byte_en = '0;
        if (i_valid && is_store) begin
            case (size)
                procyon_lsu_pkg::LSU_SIZE_BYTE: byte_en = 4'b0001 << addr[1:0];
                procyon_lsu_pkg::LSU_SIZE_HALF: byte_en = addr[1] ? 4'b1100 : 4'b0011;
                default:                        byte_en = 4'b1111;
            endcase
        end
    end

    // Move the store byte or halfword up into the lane it lands in
    // Lanes outside the enables carry don't-care zeros
    always_comb begin
        case (size)
            procyon_lsu_pkg::LSU_SIZE_BYTE:
                store_data = {24'b0, i_store_data[7:0]} << {addr[1:0], 3'b000};
            procyon_lsu_pkg::LSU_SIZE_HALF:
                store_data = {16'b0, i_store_data[15:0]} << {addr[1], 4'b0000};
            default:
                store_data = i_store_data;
        endcase
    end

    // Control state, cleared so nothing is written or completed after reset
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (~i_arst_n) begin
            o_valid   <= 1'b0;
            o_byte_en <= '0;
        end else begin
            o_valid   <= i_valid;
            o_byte_en <= byte_en;
        end
    end

    // Payload registers, only meaningful while o_valid is high
    always_ff @(posedge i_clk) begin
        o_lsu_func   <= i_lsu_func;
        o_addr       <= addr;
        o_tag        <= i_tag;
        o_store_data <= store_data;
    end

endmodule

// File: lsu_ex.sv
/* LSU execute stage: reads the data array, aligns and extends load data
   and completes stores by raising the array write enable */

`timescale 1ns/1ns

module lsu_ex (
    // Op from the address-generation register
    input  procyon_lsu_pkg::procyon_lsu_func_t i_lsu_func,
    input  procyon_types::procyon_addr_t      i_addr,
    input  procyon_types::procyon_tag_t       i_tag,
    input  logic                              i_valid,

    // Completed op towards writeback
    output procyon_types::procyon_data_t      o_data,
    output procyon_types::procyon_addr_t      o_addr,
    output procyon_types::procyon_tag_t       o_tag,
    output logic                              o_valid,

    // Data array access
    input  procyon_types::procyon_data_t      i_dc_data,
    output procyon_types::procyon_addr_t      o_dc_addr,
    output logic                              o_dc_re,
    output logic                              o_dc_we
);

    logic                          is_store;
    procyon_types::procyon_data_u  rd_word;
    logic [7:0]                    rd_byte;
    logic [15:0]                   rd_half;

    assign is_store = procyon_lsu_pkg::lsu_func_is_store(i_lsu_func);

    // Loads read the array, stores write it with the enables from address generation
    assign o_dc_addr = i_addr;
    assign o_dc_re   = i_valid & ~is_store;
    assign o_dc_we   = i_valid & is_store;

    // Address and tag pass straight on to writeback
    assign o_addr    = i_addr;
    assign o_tag     = i_tag;

    // Pick the addressed lane, accesses are assumed naturally aligned
    assign rd_word.word = i_dc_data;
    assign rd_byte      = rd_word.bytes[i_addr[1:0]];
    assign rd_half      = i_addr[1] ? {rd_word.bytes[3], rd_word.bytes[2]}
                                    : {rd_word.bytes[1], rd_word.bytes[0]};

    // LB and LH sign extend, LBU and LHU zero extend, LW passes the word
    // Stores return zero since they have no result
    always_comb begin
        case (i_lsu_func)
            procyon_lsu_pkg::LSU_FUNC_LB:  o_data = {{24{rd_byte[7]}}, rd_byte};
            procyon_lsu_pkg::LSU_FUNC_LH:  o_data = {{16{rd_half[15]}}, rd_half};
            procyon_lsu_pkg::LSU_FUNC_LW:  o_data = rd_word.word;
            procyon_lsu_pkg::LSU_FUNC_LBU: o_data = {24'b0, rd_byte};
            procyon_lsu_pkg::LSU_FUNC_LHU: o_data = {16'b0, rd_half};
            default:                       o_data = '0;
        endcase
    end

    // Every op completes here, the array always hits and stores are done
    // once their write is scheduled for the next edge
    assign o_valid = i_valid;

endmodule

// File: lsu_top.sv
/* LSU pipeline top: address generation feeding the execute stage
   and the data array it reads and writes */

`timescale 1ns/1ns

module lsu_top (
    input  logic                              i_clk,
    input  logic                              i_arst_n,

    // Op from the issue side
    input  logic                              i_valid,
    input  procyon_lsu_pkg::procyon_lsu_func_t i_lsu_func,
    input  procyon_types::procyon_addr_t      i_base,
    input  procyon_types::procyon_addr_t      i_offset,
    input  procyon_types::procyon_tag_t       i_tag,
    input  procyon_types::procyon_data_t      i_store_data,

    // Completed op, one cycle after it was sampled
    output procyon_types::procyon_data_t      o_data,
    output procyon_types::procyon_addr_t      o_addr,
    output procyon_types::procyon_tag_t       o_tag,
    output logic                              o_valid
);

    // Address generation to execute stage
    logic                                ag_valid;
    procyon_lsu_pkg::procyon_lsu_func_t  ag_lsu_func;
    procyon_types::procyon_addr_t        ag_addr;
    procyon_types::procyon_tag_t         ag_tag;

    // Address generation to the data array
    procyon_types::procyon_data_t        ag_store_data;
    procyon_types::procyon_byte_en_t     ag_byte_en;

    // Execute stage and data array
    procyon_types::procyon_addr_t        dc_addr;
    logic                                dc_re;
    logic                                dc_we;
    procyon_types::procyon_data_t        dc_rd_data;

    lsu_ag lsu_ag_inst (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_valid      (i_valid),
        .i_lsu_func   (i_lsu_func),
        .i_base       (i_base),
        .i_offset     (i_offset),
        .i_tag        (i_tag),
        .i_store_data (i_store_data),
        .o_valid      (ag_valid),
        .o_lsu_func   (ag_lsu_func),
        .o_addr       (ag_addr),
        .o_tag        (ag_tag),
        .o_store_data (ag_store_data),
        .o_byte_en    (ag_byte_en)
    );

    dc_data_ram dc_data_ram_inst (
        .i_clk     (i_clk),
        .i_addr    (dc_addr),
        .i_re      (dc_re),
        .o_rd_data (dc_rd_data),
        .i_we      (dc_we),
        .i_byte_en (ag_byte_en),
        .i_wr_data (ag_store_data)
    );

    lsu_ex lsu_ex_inst (
        .i_lsu_func (ag_lsu_func),
        .i_addr     (ag_addr),
        .i_tag      (ag_tag),
        .i_valid    (ag_valid),
        .o_data     (o_data),
        .o_addr     (o_addr),
        .o_tag      (o_tag),
        .o_valid    (o_valid),
        .i_dc_data  (dc_rd_data),
        .o_dc_addr  (dc_addr),
        .o_dc_re    (dc_re),
        .o_dc_we    (dc_we)
    );

endmodule

// File: lsu_top_asserts.sv
/* Concurrent checks on the LSU pipeline: access alignment, array write enable
   and one completion per accepted op, bound into lsu_top */

`timescale 1ns/1ns

module lsu_top_asserts (
    input logic                               i_clk,
    input logic                               i_arst_n,
    input logic                               i_valid,
    input logic                               i_ag_valid,
    input procyon_lsu_pkg::procyon_lsu_func_t i_ag_lsu_func,
    input procyon_types::procyon_addr_t       i_ag_addr,
    input procyon_types::procyon_byte_en_t    i_ag_byte_en,
    input logic                               i_dc_we,
    input logic                               i_out_valid
);

    logic [1:0] ag_size;
    logic       ag_store_func;

    assign ag_size = procyon_lsu_pkg::lsu_func_size(i_ag_lsu_func);

    // Store functions listed directly from the function encoding
    assign ag_store_func = i_ag_lsu_func inside {procyon_lsu_pkg::LSU_FUNC_SB,
                                                 procyon_lsu_pkg::LSU_FUNC_SH,
                                                 procyon_lsu_pkg::LSU_FUNC_SW};

    // Halfword accesses sit on even addresses
    half_aligned: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_ag_valid && ag_size == procyon_lsu_pkg::LSU_SIZE_HALF) |-> (i_ag_addr[0] == 1'b0))
        else $error("Halfword access at odd address 0x%08h", i_ag_addr);

    // Word accesses sit on 4-byte boundaries
    word_aligned: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_ag_valid && ag_size == procyon_lsu_pkg::LSU_SIZE_WORD) |-> (i_ag_addr[1:0] == 2'b00))
        else $error("Word access at unaligned address 0x%08h", i_ag_addr);

    // A load never writes the array, neither through the enable nor through a lane enable
    we_store_only: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !ag_store_func |-> (!i_dc_we && i_ag_byte_en == '0))
        else $error("Array write enabled for a load function");

    // Each accepted op completes exactly one cycle later
    completes_once: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_valid |=> i_out_valid)
        else $error("Accepted op did not complete in the following cycle");

    no_spurious_valid: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !i_valid |=> !i_out_valid)
        else $error("Output valid without an op accepted in the previous cycle");

endmodule

bind lsu_top lsu_top_asserts lsu_top_asserts_inst (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_valid       (i_valid),
    .i_ag_valid    (ag_valid),
    .i_ag_lsu_func (ag_lsu_func),
    .i_ag_addr     (ag_addr),
    .i_ag_byte_en  (ag_byte_en),
    .i_dc_we       (dc_we),
    .i_out_valid   (o_valid)
);

// File: procyon_lsu_pkg.sv
/* LSU function codes, access-size codes and helpers that classify a function
   by access size and by load or store direction */

package procyon_lsu_pkg;

    // Function codes of the load/store unit
    typedef enum logic [3:0] {
        LSU_FUNC_LB  = 4'b0000,
        LSU_FUNC_LH  = 4'b0001,
        LSU_FUNC_LW  = 4'b0010,
        LSU_FUNC_LBU = 4'b0011,
        LSU_FUNC_LHU = 4'b0100,
        LSU_FUNC_SB  = 4'b0101,
        LSU_FUNC_SH  = 4'b0110,
        LSU_FUNC_SW  = 4'b0111
    } procyon_lsu_func_t;

    // Access sizes, a word access covers all four byte lanes
    localparam logic [1:0] LSU_SIZE_BYTE = 2'b00;
    localparam logic [1:0] LSU_SIZE_HALF = 2'b01;
    localparam logic [1:0] LSU_SIZE_WORD = 2'b10;

    // Map a function code onto the size of the memory access it performs
    function automatic logic [1:0] lsu_func_size(input procyon_lsu_func_t func);
        case (func)
            LSU_FUNC_LB, LSU_FUNC_LBU, LSU_FUNC_SB: lsu_func_size = LSU_SIZE_BYTE;
            LSU_FUNC_LH, LSU_FUNC_LHU, LSU_FUNC_SH: lsu_func_size = LSU_SIZE_HALF;
            default:                                lsu_func_size = LSU_SIZE_WORD;
        endcase
    endfunction

    // True for the three store functions, false for every load
    function automatic logic lsu_func_is_store(input procyon_lsu_func_t func);
        case (func)
            LSU_FUNC_SB, LSU_FUNC_SH, LSU_FUNC_SW: lsu_func_is_store = 1'b1;
            default:                               lsu_func_is_store = 1'b0;
        endcase
    endfunction

endpackage

// File: procyon_types.sv
/* Core data, address and tag widths, data-cache geometry and the shared data word types
   including the packed union that gives both a word view and a byte-lane view */

package procyon_types;

    // Machine word and byte address sizes for this ISA
    localparam int DATA_WIDTH     = 32;
    localparam int ADDR_WIDTH     = 32;

    // Destination tag carried alongside each op to its writeback consumer
    localparam int TAG_WIDTH      = 6;

    // Data-cache array geometry; index comes from word address bits
    localparam int DC_DEPTH       = 64;
    localparam int DC_INDEX_WIDTH = 6;

    // Number of byte lanes in one data word
    localparam int DATA_BYTES     = DATA_WIDTH / 8;

    typedef logic [DATA_WIDTH-1:0]  procyon_data_t;
    typedef logic [ADDR_WIDTH-1:0]  procyon_addr_t;
    typedef logic [TAG_WIDTH-1:0]   procyon_tag_t;

    // One write enable per byte lane, bit 0 is the least significant byte
    typedef logic [DATA_BYTES-1:0]  procyon_byte_en_t;

    // One data word, seen either whole or split into its byte lanes
    // The execute stage picks load lanes from the byte view
    // The data array merges enabled store bytes through the same view
    typedef union packed {
        procyon_data_t                     word;
        logic [DATA_BYTES-1:0][7:0]        bytes;
    } procyon_data_u;

endpackage

// File: tb_lsu_top.sv
/* Directed testbench for the LSU pipeline with a word memory model,
   typed compare tasks and a cycle-count timeout */

`timescale 1ns/1ns

module tb_lsu_top;

    // All tests together take well under a hundred cycles
    localparam int TIMEOUT_CYCLES = 400;

    logic                               clk;
    logic                               arst_n;
    logic                               valid;
    procyon_lsu_pkg::procyon_lsu_func_t lsu_func;
    procyon_types::procyon_addr_t       base;
    procyon_types::procyon_addr_t       offset;
    procyon_types::procyon_tag_t        tag;
    procyon_types::procyon_data_t       store_data;

    procyon_types::procyon_data_t       out_data;
    procyon_types::procyon_addr_t       out_addr;
    procyon_types::procyon_tag_t        out_tag;
    logic                               out_valid;

    // Reference copy of the array, updated in the order ops are issued
    procyon_types::procyon_data_t       model_mem [procyon_types::DC_DEPTH];

    // Result expected from the op sampled at the most recent rising edge
    logic                               exp_valid;
    procyon_types::procyon_data_t       exp_data;
    procyon_types::procyon_addr_t       exp_addr;
    procyon_types::procyon_tag_t        exp_tag;

    procyon_types::procyon_tag_t        next_tag;
    integer                             seed;
    int                                 cycle_count;

    lsu_top i_lsu_top (
        .i_clk        (clk),
        .i_arst_n     (arst_n),
        .i_valid      (valid),
        .i_lsu_func   (lsu_func),
        .i_base       (base),
        .i_offset     (offset),
        .i_tag        (tag),
        .i_store_data (store_data),
        .o_data       (out_data),
        .o_addr       (out_addr),
        .o_tag        (out_tag),
        .o_valid      (out_valid)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            end_with_failure();
        end
    end

    task automatic end_with_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic compare_data(input string name, input procyon_types::procyon_data_t actual,
                                input procyon_types::procyon_data_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            end_with_failure();
        end
    endtask

    task automatic compare_addr(input string name, input procyon_types::procyon_addr_t actual,
                                input procyon_types::procyon_addr_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            end_with_failure();
        end
    endtask

    task automatic compare_tag(input string name, input procyon_types::procyon_tag_t actual,
                               input procyon_types::procyon_tag_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
            end_with_failure();
        end
    endtask

    task automatic compare_valid(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, actual, expected);
            end_with_failure();
        end
    endtask

    // Number of bytes an access touches
    function automatic int access_bytes(input procyon_lsu_pkg::procyon_lsu_func_t func);
        case (func)
            procyon_lsu_pkg::LSU_FUNC_LB, procyon_lsu_pkg::LSU_FUNC_LBU,
            procyon_lsu_pkg::LSU_FUNC_SB: return 1;
            procyon_lsu_pkg::LSU_FUNC_LH, procyon_lsu_pkg::LSU_FUNC_LHU,
            procyon_lsu_pkg::LSU_FUNC_SH: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic model_is_store(input procyon_lsu_pkg::procyon_lsu_func_t func);
        return (func == procyon_lsu_pkg::LSU_FUNC_SB) || (func == procyon_lsu_pkg::LSU_FUNC_SH) ||
               (func == procyon_lsu_pkg::LSU_FUNC_SW);
    endfunction

    // Overwrite only the bytes the store covers, starting at the addressed lane
    task automatic model_write(input procyon_lsu_pkg::procyon_lsu_func_t func,
                               input procyon_types::procyon_addr_t addr,
                               input procyon_types::procyon_data_t data);
        int idx;
        int lane;
        idx  = int'(addr[procyon_types::DC_INDEX_WIDTH+1:2]);
        lane = int'(addr[1:0]);
        case (access_bytes(func))
            1:       model_mem[idx][8*lane +: 8]  = data[7:0];
            2:       model_mem[idx][8*lane +: 16] = data[15:0];
            default: model_mem[idx]               = data;
        endcase
    endtask

    // Expected load result with sign or zero extension
    function automatic procyon_types::procyon_data_t model_read(
            input procyon_lsu_pkg::procyon_lsu_func_t func, input procyon_types::procyon_addr_t addr);
        procyon_types::procyon_data_t word;
        logic [7:0]                   sel_byte;
        logic [15:0]                  sel_half;
        word     = model_mem[int'(addr[procyon_types::DC_INDEX_WIDTH+1:2])];
        sel_byte = word[8*int'(addr[1:0]) +: 8];
        sel_half = word[16*int'(addr[1]) +: 16];
        case (func)
            procyon_lsu_pkg::LSU_FUNC_LB:  return {{24{sel_byte[7]}}, sel_byte};
            procyon_lsu_pkg::LSU_FUNC_LBU: return {24'b0, sel_byte};
            procyon_lsu_pkg::LSU_FUNC_LH:  return {{16{sel_half[15]}}, sel_half};
            procyon_lsu_pkg::LSU_FUNC_LHU: return {16'b0, sel_half};
            procyon_lsu_pkg::LSU_FUNC_LW:  return word;
            default:                       return '0;
        endcase
    endfunction

    // Outputs settle after the edge and hold until the next one, so check mid-cycle
    task automatic check_result();
        @(negedge clk);
        compare_valid("o_valid", out_valid, exp_valid);
        if (exp_valid) begin
            compare_data("o_data", out_data, exp_data);
            compare_addr("o_addr", out_addr, exp_addr);
            compare_tag("o_tag", out_tag, exp_tag);
        end
    endtask

    // Present one op and check the result of the op issued in the previous cycle
    task automatic issue_op(input procyon_lsu_pkg::procyon_lsu_func_t func,
                            input procyon_types::procyon_addr_t op_base,
                            input procyon_types::procyon_addr_t op_offset,
                            input procyon_types::procyon_data_t op_data);
        procyon_types::procyon_addr_t addr;
        addr = op_base + op_offset;
        @(posedge clk);
        #1;
        valid      = 1'b1;
        lsu_func   = func;
        base       = op_base;
        offset     = op_offset;
        tag        = next_tag;
        store_data = op_data;
        check_result();
        exp_valid = 1'b1;
        exp_addr  = addr;
        exp_tag   = next_tag;
        if (model_is_store(func)) begin
            model_write(func, addr, op_data);
            exp_data = '0;
        end else begin
            exp_data = model_read(func, addr);
        end
        next_tag = next_tag + 1'b1;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        valid = 1'b0;
        check_result();
        exp_valid = 1'b0;
    endtask

    task automatic test_reset_idle();
        $display("Test: no valid output after reset");
        repeat (4) idle_cycle();
    endtask

    task automatic test_word_store_load();
        procyon_types::procyon_addr_t word_base;
        $display("Test: word stores then word loads");
        word_base = procyon_types::procyon_addr_t'($random(seed)) & 32'hFFFF_FF00;
        for (int i = 0; i < 8; i++) begin
            issue_op(procyon_lsu_pkg::LSU_FUNC_SW, word_base,
                     procyon_types::procyon_addr_t'(i * 20 + 8), $random(seed));
        end
        for (int i = 0; i < 8; i++) begin
            issue_op(procyon_lsu_pkg::LSU_FUNC_LW, word_base,
                     procyon_types::procyon_addr_t'(i * 20 + 8), '0);
        end
    endtask

    task automatic test_byte_lanes();
        procyon_types::procyon_addr_t lane_base;
        $display("Test: byte and halfword stores merged into words");
        lane_base = (procyon_types::procyon_addr_t'($random(seed)) & 32'hFFFF_FF00) | 32'hA0;
        for (int lane = 0; lane < 4; lane++) begin
            issue_op(procyon_lsu_pkg::LSU_FUNC_SB, lane_base,
                     procyon_types::procyon_addr_t'(lane), $random(seed));
        end
        issue_op(procyon_lsu_pkg::LSU_FUNC_LW, lane_base, 32'h0, '0);
        issue_op(procyon_lsu_pkg::LSU_FUNC_SH, lane_base, 32'h4, $random(seed));
        issue_op(procyon_lsu_pkg::LSU_FUNC_SH, lane_base, 32'h6, $random(seed));
        issue_op(procyon_lsu_pkg::LSU_FUNC_LW, lane_base, 32'h4, '0);
    endtask

    task automatic test_load_extension();
        procyon_types::procyon_addr_t ext_base;
        $display("Test: sign and zero extension of byte and halfword loads");
        ext_base = (procyon_types::procyon_addr_t'($random(seed)) & 32'hFFFF_FF00) | 32'h60;
        // Lanes mix set and clear top bits so both extensions show up
        issue_op(procyon_lsu_pkg::LSU_FUNC_SW, ext_base, 32'h0, 32'h807F_FF01);
        issue_op(procyon_lsu_pkg::LSU_FUNC_SW, ext_base, 32'h4, 32'h7FFF_8000);
        for (int lane = 0; lane < 4; lane++) begin
            issue_op(procyon_lsu_pkg::LSU_FUNC_LB, ext_base,
                     procyon_types::procyon_addr_t'(lane), '0);
            issue_op(procyon_lsu_pkg::LSU_FUNC_LBU, ext_base,
                     procyon_types::procyon_addr_t'(lane), '0);
        end
        for (int half = 0; half < 4; half++) begin
            issue_op(procyon_lsu_pkg::LSU_FUNC_LH, ext_base,
                     procyon_types::procyon_addr_t'(half * 2), '0);
            issue_op(procyon_lsu_pkg::LSU_FUNC_LHU, ext_base,
                     procyon_types::procyon_addr_t'(half * 2), '0);
        end
    endtask

    task automatic test_back_to_back();
        procyon_types::procyon_addr_t       pair_base;
        procyon_types::procyon_addr_t       op_offset;
        procyon_lsu_pkg::procyon_lsu_func_t func;
        logic [31:0]                        r;
        $display("Test: back to back store and load, then a stream of mixed ops");
        pair_base = (procyon_types::procyon_addr_t'($random(seed)) & 32'hFFFF_FF00) | 32'hC0;
        for (int i = 0; i < 4; i++) begin
            issue_op(procyon_lsu_pkg::LSU_FUNC_SW, pair_base,
                     procyon_types::procyon_addr_t'(i * 4), $random(seed));
            issue_op(procyon_lsu_pkg::LSU_FUNC_LW, pair_base,
                     procyon_types::procyon_addr_t'(i * 4), '0);
            issue_op(procyon_lsu_pkg::LSU_FUNC_SB, pair_base,
                     procyon_types::procyon_addr_t'(i * 5), $random(seed));
            issue_op(procyon_lsu_pkg::LSU_FUNC_LBU, pair_base,
                     procyon_types::procyon_addr_t'(i * 5), '0);
        end
        // Random functions over the same four words, each aligned to its size
        for (int i = 0; i < 16; i++) begin
            r         = $random(seed);
            func      = procyon_lsu_pkg::procyon_lsu_func_t'({1'b0, r[2:0]});
            op_offset = procyon_types::procyon_addr_t'(r[7:4]) &
                        ~procyon_types::procyon_addr_t'(access_bytes(func) - 1);
            issue_op(func, pair_base, op_offset, $random(seed));
        end
    endtask

    task automatic test_store_completion();
        $display("Test: stores complete with zero data");
        issue_op(procyon_lsu_pkg::LSU_FUNC_SB, 32'h0000_1003, 32'h0, 32'hFFFF_FFFF);
        issue_op(procyon_lsu_pkg::LSU_FUNC_SH, 32'h0000_1000, 32'h6, 32'hFFFF_FFFF);
        issue_op(procyon_lsu_pkg::LSU_FUNC_SW, 32'h0000_1000, 32'h8, 32'hFFFF_FFFF);
        idle_cycle();
    endtask

    initial begin
        clk         = 1'b0;
        seed        = 14;
        cycle_count = 0;
        next_tag    = '0;
        exp_valid   = 1'b0;
        exp_data    = '0;
        exp_addr    = '0;
        exp_tag     = '0;
        arst_n      = 1'b0;
        valid       = 1'b0;
        lsu_func    = procyon_lsu_pkg::LSU_FUNC_LW;
        base        = '0;
        offset      = '0;
        tag         = '0;
        store_data  = '0;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;

        test_reset_idle();
        test_word_store_load();
        test_byte_lanes();
        test_load_extension();
        test_back_to_back();
        test_store_completion();

        // Last op still has to be checked
        idle_cycle();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
